//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // shift group shares bit 2 (variable) and bits 1:0 (kind)
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam logic [4:0] RT_BLTZ = 5'h00;
    localparam logic [4:0] RT_BGEZ = 5'h01;
    localparam logic [4:0] RA_REG  = 5'd31;

    typedef struct packed {
        logic [5:0]        op;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [4:0]        sa;
        logic [5:0]        funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]        op;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [15:0]       imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

`default_nettype wire

//--- design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    import isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        LS_NOP,
        LS_LB,
        LS_LBU,
        LS_LH,
        LS_LHU,
        LS_LW,
        LS_SB,
        LS_SH,
        LS_SW
    } ls_op_e;

    typedef enum logic {
        SRC_A_RS,
        SRC_A_RT
    } src_a_e;

    // five choices, so three bits
    typedef enum logic [2:0] {
        SRC_B_NOP,
        SRC_B_RT,
        SRC_B_IMM,
        SRC_B_RS,
        SRC_B_SA
    } src_b_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX_RES,
        FWD_MEM_RES,
        FWD_MEM_LOAD
    } fwd_sel_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } fetch_in_t;

    typedef struct packed {
        logic [XLEN-1:0] ex_res;
        logic [XLEN-1:0] mem_res;
        logic [XLEN-1:0] mem_load;
    } fwd_bus_t;

    typedef struct packed {
        logic              ena;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } reg_wr_t;

    typedef struct packed {
        alu_op_e           alu_op;
        src_a_e            src_a;
        src_b_e            src_b;
        ls_op_e            ls_op;
        logic              wb_from_mem;
        logic              link;
        logic              w_reg_ena;
        logic [REG_AW-1:0] w_reg_dst;
        logic              sign_ext;
        logic              check_ov;
        logic              is_ri;
        logic              is_branch;
        logic              is_j_imm;
        logic              is_jr;
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [4:0]        sa;
        logic [XLEN-1:0]   rs_data;
        logic [XLEN-1:0]   rt_data;
        logic [XLEN-1:0]   ext_imme;
        ctrl_t             ctrl;
        logic              take_jmp;
        logic [XLEN-1:0]   jmp_target;
    } decode_out_t;

endpackage

`default_nettype wire

//--- design/operand_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module operand_fetch import isa_pkg::*, ctrl_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [REG_AW-1:0] rs_addr,
    input  logic [REG_AW-1:0] rt_addr,
    input  fwd_sel_e          fwd_rs_sel,
    input  fwd_sel_e          fwd_rt_sel,
    input  fwd_bus_t          fwd,
    input  reg_wr_t           wb,
    output logic [XLEN-1:0]   rs_data,
    output logic [XLEN-1:0]   rt_data
);

    // r0 has no storage
    logic [XLEN-1:0] rf [1:(2**REG_AW)-1];
    logic [XLEN-1:0] rs_reg;
    logic [XLEN-1:0] rt_reg;

    function automatic logic [XLEN-1:0] pick(input fwd_sel_e sel,
                                             input fwd_bus_t bus,
                                             input logic [XLEN-1:0] reg_val);
        case (sel)
            FWD_EX_RES:   return bus.ex_res;
            FWD_MEM_RES:  return bus.mem_res;
            FWD_MEM_LOAD: return bus.mem_load;
            default:      return reg_val;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 2**REG_AW; i++) begin
                rf[i] <= '0;
            end
        end else if (wb.ena && wb.addr != '0) begin
            rf[wb.addr] <= wb.data;
        end
    end

    // same-cycle write is not bypassed here, forwarding covers it
    assign rs_reg = (rs_addr == '0) ? '0 : rf[rs_addr];
    assign rt_reg = (rt_addr == '0) ? '0 : rf[rt_addr];

    assign rs_data = pick(fwd_rs_sel, fwd, rs_reg);
    assign rt_data = pick(fwd_rt_sel, fwd, rt_reg);

endmodule

`default_nettype wire

//--- design/ctrl_decode.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_decode import isa_pkg::*, ctrl_pkg::*; (
    input  instr_u instr,
    output ctrl_t  ctrl
);

    logic [REG_AW-1:0] dst;
    logic              wr;
    logic              ri;

    always_comb begin
        ctrl = '0;
        dst  = '0;
        wr   = 1'b0;
        ri   = 1'b0;
        case (instr.r_fmt.op)
            OP_SPECIAL: begin
                dst        = instr.r_fmt.rd;
                wr         = 1'b1;
                ctrl.src_b = SRC_B_RT;
                case (instr.r_fmt.funct)
                    FN_ADD: begin
                        ctrl.alu_op   = ALU_ADD;
                        ctrl.check_ov = 1'b1;
                    end
                    FN_SUB: begin
                        ctrl.alu_op   = ALU_SUB;
                        ctrl.check_ov = 1'b1;
                    end
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
                        ctrl.src_a = SRC_A_RT;
                        if (instr.r_fmt.funct[2]) begin
                            ctrl.src_b = SRC_B_RS;
                        end else begin
                            ctrl.src_b = SRC_B_SA;
                        end
                        // funct[1:0]: 00 left, 10 logical right, 11 arithmetic
                        if (!instr.r_fmt.funct[1]) begin
                            ctrl.alu_op = ALU_SLL;
                        end else if (instr.r_fmt.funct[0]) begin
                            ctrl.alu_op = ALU_SRA;
                        end else begin
                            ctrl.alu_op = ALU_SRL;
                        end
                    end
                    FN_JR: begin
                        ctrl.src_b = SRC_B_NOP;
                        ctrl.is_jr = 1'b1;
                        wr         = 1'b0;
                    end
                    FN_JALR: begin
                        ctrl.src_b = SRC_B_NOP;
                        ctrl.is_jr = 1'b1;
                        ctrl.link  = 1'b1;
                    end
                    default: ri = 1'b1;
                endcase
            end
            OP_REGIMM: begin
                if (instr.i_fmt.rt == RT_BLTZ || instr.i_fmt.rt == RT_BGEZ) begin
                    ctrl.is_branch = 1'b1;
                end else begin
                    ri = 1'b1;
                end
            end
            OP_J: ctrl.is_j_imm = 1'b1;
            OP_JAL: begin
                ctrl.is_j_imm = 1'b1;
                ctrl.link     = 1'b1;
                dst           = RA_REG;
                wr            = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: ctrl.is_branch = 1'b1;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.src_b    = SRC_B_IMM;
                ctrl.sign_ext = !instr.i_fmt.op[2];
                ctrl.check_ov = (instr.i_fmt.op == OP_ADDI);
                dst           = instr.i_fmt.rt;
                wr            = 1'b1;
                case (instr.i_fmt.op)
                    OP_SLTI:  ctrl.alu_op = ALU_SLT;
                    OP_SLTIU: ctrl.alu_op = ALU_SLTU;
                    OP_ANDI:  ctrl.alu_op = ALU_AND;
                    OP_ORI:   ctrl.alu_op = ALU_OR;
                    OP_XORI:  ctrl.alu_op = ALU_XOR;
                    OP_LUI:   ctrl.alu_op = ALU_LUI;
                    default:  ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW: begin
                ctrl.alu_op   = ALU_ADD;
                ctrl.src_b    = SRC_B_IMM;
                ctrl.sign_ext = 1'b1;
                // loads sit below 6'h28, stores at or above
                ctrl.wb_from_mem = !instr.i_fmt.op[3];
                wr               = !instr.i_fmt.op[3];
                dst              = instr.i_fmt.rt;
                case (instr.i_fmt.op)
                    OP_LB:   ctrl.ls_op = LS_LB;
                    OP_LBU:  ctrl.ls_op = LS_LBU;
                    OP_LH:   ctrl.ls_op = LS_LH;
                    OP_LHU:  ctrl.ls_op = LS_LHU;
                    OP_LW:   ctrl.ls_op = LS_LW;
                    OP_SB:   ctrl.ls_op = LS_SB;
                    OP_SH:   ctrl.ls_op = LS_SH;
                    default: ctrl.ls_op = LS_SW;
                endcase
            end
            default: ri = 1'b1;
        endcase

        if (ri) begin
            ctrl       = '0;
            ctrl.is_ri = 1'b1;
        end else begin
            ctrl.w_reg_dst = dst;
            ctrl.w_reg_ena = wr && (dst != '0);
        end
    end

endmodule

`default_nettype wire

//--- design/branch_issue.sv
`timescale 1ns/10ps
`default_nettype none

module branch_issue import isa_pkg::*, ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  fetch_in_t       in,
    input  ctrl_t           ctrl,
    input  logic [XLEN-1:0] rs_data,
    input  logic [XLEN-1:0] rt_data,
    output decode_out_t     out
);

    logic            rs_neg;
    logic            rs_zero;
    logic            cond;
    logic            take;
    logic [XLEN-1:0] br_target;
    decode_out_t     nxt;

    assign rs_neg  = rs_data[XLEN-1];
    assign rs_zero = (rs_data == '0);

    always_comb begin
        case (in.instr.i_fmt.op)
            OP_BEQ:    cond = (rs_data == rt_data);
            OP_BNE:    cond = (rs_data != rt_data);
            OP_BLEZ:   cond = rs_neg || rs_zero;
            OP_BGTZ:   cond = !rs_neg && !rs_zero;
            OP_REGIMM: cond = (in.instr.i_fmt.rt == RT_BGEZ) ? !rs_neg : rs_neg;
            default:   cond = 1'b0;
        endcase
    end

    assign take = ctrl.is_j_imm || ctrl.is_jr || (ctrl.is_branch && cond);

    // pc+4 plus word offset
    assign br_target = in.pc + XLEN'(4)
                     + {{(XLEN-18){in.instr.i_fmt.imm16[15]}}, in.instr.i_fmt.imm16, 2'b00};

    always_comb begin
        nxt         = '0;
        nxt.valid   = in.valid;
        nxt.pc      = in.pc;
        nxt.rs      = in.instr.r_fmt.rs;
        nxt.rt      = in.instr.r_fmt.rt;
        nxt.sa      = in.instr.r_fmt.sa;
        nxt.rs_data = rs_data;
        nxt.rt_data = rt_data;
        if (ctrl.sign_ext) begin
            nxt.ext_imme = {{(XLEN-16){in.instr.i_fmt.imm16[15]}}, in.instr.i_fmt.imm16};
        end else begin
            nxt.ext_imme = {{(XLEN-16){1'b0}}, in.instr.i_fmt.imm16};
        end
        nxt.ctrl           = ctrl;
        nxt.ctrl.w_reg_ena = ctrl.w_reg_ena && in.valid;
        nxt.take_jmp       = take && in.valid;
        if (ctrl.is_j_imm) begin
            nxt.jmp_target = {in.pc[XLEN-1:XLEN-4], in.instr.j_fmt.target26, 2'b00};
        end else if (ctrl.is_jr) begin
            nxt.jmp_target = rs_data;
        end else begin
            nxt.jmp_target = br_target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import isa_pkg::*, ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fetch_in_t   in,
    input  fwd_sel_e    fwd_rs_sel,
    input  fwd_sel_e    fwd_rt_sel,
    input  fwd_bus_t    fwd,
    input  reg_wr_t     wb,
    output decode_out_t out
);

    ctrl_t           ctrl;
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;

    operand_fetch u_operand_fetch (
        .clk        (clk),
        .rst        (rst),
        .rs_addr    (in.instr.r_fmt.rs),
        .rt_addr    (in.instr.r_fmt.rt),
        .fwd_rs_sel (fwd_rs_sel),
        .fwd_rt_sel (fwd_rt_sel),
        .fwd        (fwd),
        .wb         (wb),
        .rs_data    (rs_data),
        .rt_data    (rt_data)
    );

    ctrl_decode u_ctrl_decode (
        .instr (in.instr),
        .ctrl  (ctrl)
    );

    branch_issue u_branch_issue (
        .clk     (clk),
        .rst     (rst),
        .in      (in),
        .ctrl    (ctrl),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .out     (out)
    );

endmodule

`default_nettype wire

//--- tb/tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage import isa_pkg::*, ctrl_pkg::*; ();

    localparam int RESET_TIMEOUT = 64;
    localparam int MAX_LINES     = 200;

    logic        clk;
    logic        rst;
    fetch_in_t   fetch_in;
    fwd_sel_e    fwd_rs_sel;
    fwd_sel_e    fwd_rt_sel;
    fwd_bus_t    fwd;
    reg_wr_t     wb;
    decode_out_t out;

    // register model, r0 never written
    logic [XLEN-1:0] regs [0:31];
    logic [31:0]     rand_state;
    int              mismatches;
    int              other_errors;
    int              line_no;

    // fields of the current D line
    logic [31:0] pc_v;
    logic [31:0] instr_v;
    logic [31:0] rs_sel_v;
    logic [31:0] rt_sel_v;
    logic [31:0] exp_alu;
    logic [31:0] exp_src_a;
    logic [31:0] exp_src_b;
    logic [31:0] exp_ls;
    logic [31:0] exp_wena;
    logic [31:0] exp_dst;
    logic [31:0] exp_imme;
    logic [31:0] exp_ri;
    logic [31:0] exp_take;
    logic [31:0] exp_target;

    decode_stage u_decode_stage (
        .clk        (clk),
        .rst        (rst),
        .in         (fetch_in),
        .fwd_rs_sel (fwd_rs_sel),
        .fwd_rt_sel (fwd_rt_sel),
        .fwd        (fwd),
        .wb         (wb),
        .out        (out)
    );

    always #10 clk = ~clk;

    initial begin
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] expected_operand(input logic [1:0] sel,
                                                     input logic [4:0] addr);
        case (sel)
            FWD_EX_RES:   return fwd.ex_res;
            FWD_MEM_RES:  return fwd.mem_res;
            FWD_MEM_LOAD: return fwd.mem_load;
            default:      return regs[addr];
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Mismatch %s: got %h, expected %h (stim line %0d)",
                 name, got, expected, line_no);
        mismatches++;
    endtask

    task automatic apply_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        fetch_in.valid = 1'b0;
        wb.ena         = 1'b1;
        wb.addr        = addr;
        wb.data        = data;
        if (addr != 5'd0) begin
            regs[addr] = data;
        end
        @(posedge clk);
        #2;
        wb.ena = 1'b0;
        // instruction of the last D line is still on the bus
        if (out.valid !== 1'b0) report_mismatch("valid", out.valid, 32'd0);
        if (out.take_jmp !== 1'b0) report_mismatch("take_jmp", out.take_jmp, 32'd0);
        if (out.ctrl.w_reg_ena !== 1'b0) report_mismatch("w_reg_ena", out.ctrl.w_reg_ena, 32'd0);
    endtask

    task automatic check_decode;
        logic [31:0] exp_rs;
        logic [31:0] exp_rt;
        logic        exp_mem;
        logic [5:0]  op;
        logic [5:0]  funct;
        logic        exp_ov;
        logic        exp_link;
        @(posedge clk);
        #2;
        rand_state   = xorshift32(rand_state);
        fwd.ex_res   = rand_state;
        rand_state   = xorshift32(rand_state);
        fwd.mem_res  = rand_state;
        rand_state   = xorshift32(rand_state);
        fwd.mem_load = rand_state;
        fetch_in.valid = 1'b1;
        fetch_in.pc    = pc_v;
        fetch_in.instr = instr_v;
        fwd_rs_sel     = fwd_sel_e'(rs_sel_v[1:0]);
        fwd_rt_sel     = fwd_sel_e'(rt_sel_v[1:0]);
        exp_rs  = expected_operand(rs_sel_v[1:0], instr_v[25:21]);
        exp_rt  = expected_operand(rt_sel_v[1:0], instr_v[20:16]);
        exp_mem = (exp_ls[3:0] >= LS_LB) && (exp_ls[3:0] <= LS_LW);
        op      = instr_v[31:26];
        funct   = instr_v[5:0];
        // add, sub and addi trap on overflow
        exp_ov   = (op == OP_ADDI)
                 || (op == OP_SPECIAL && (funct == FN_ADD || funct == FN_SUB));
        exp_link = (op == OP_JAL) || (op == OP_SPECIAL && funct == FN_JALR);
        // jr and jalr jump to whatever rs resolves to
        if (exp_target == 32'hffff_ffff) begin
            exp_target = exp_rs;
        end
        @(posedge clk);
        #2;
        if (out.valid !== 1'b1) report_mismatch("valid", out.valid, 32'd1);
        if (out.pc !== pc_v) report_mismatch("pc", out.pc, pc_v);
        if (out.rs !== instr_v[25:21]) report_mismatch("rs", out.rs, instr_v[25:21]);
        if (out.rt !== instr_v[20:16]) report_mismatch("rt", out.rt, instr_v[20:16]);
        if (out.sa !== instr_v[10:6]) report_mismatch("sa", out.sa, instr_v[10:6]);
        if (out.ctrl.alu_op !== exp_alu[3:0]) report_mismatch("alu_op", out.ctrl.alu_op, exp_alu);
        if (out.ctrl.src_a !== exp_src_a[0]) report_mismatch("src_a", out.ctrl.src_a, exp_src_a);
        if (out.ctrl.src_b !== exp_src_b[2:0]) report_mismatch("src_b", out.ctrl.src_b, exp_src_b);
        if (out.ctrl.ls_op !== exp_ls[3:0]) report_mismatch("ls_op", out.ctrl.ls_op, exp_ls);
        if (out.ctrl.wb_from_mem !== exp_mem) begin
            report_mismatch("wb_from_mem", out.ctrl.wb_from_mem, exp_mem);
        end
        if (out.ctrl.w_reg_ena !== exp_wena[0]) begin
            report_mismatch("w_reg_ena", out.ctrl.w_reg_ena, exp_wena);
        end
        if (out.ctrl.w_reg_dst !== exp_dst[4:0]) begin
            report_mismatch("w_reg_dst", out.ctrl.w_reg_dst, exp_dst);
        end
        if (out.ctrl.check_ov !== exp_ov) begin
            report_mismatch("check_ov", out.ctrl.check_ov, exp_ov);
        end
        if (out.ctrl.link !== exp_link) begin
            report_mismatch("link", out.ctrl.link, exp_link);
        end
        if (out.ext_imme !== exp_imme) report_mismatch("ext_imme", out.ext_imme, exp_imme);
        if (out.ctrl.is_ri !== exp_ri[0]) report_mismatch("is_ri", out.ctrl.is_ri, exp_ri);
        if (out.take_jmp !== exp_take[0]) report_mismatch("take_jmp", out.take_jmp, exp_take);
        if (exp_take[0] && out.jmp_target !== exp_target) begin
            report_mismatch("jmp_target", out.jmp_target, exp_target);
        end
        if (out.rs_data !== exp_rs) report_mismatch("rs_data", out.rs_data, exp_rs);
        if (out.rt_data !== exp_rt) report_mismatch("rt_data", out.rt_data, exp_rt);
    endtask

    task automatic run_stimulus;
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [31:0]      w_addr;
        logic [31:0]      w_data;
        logic [8*128-1:0] skipped;
        logic             done;
        fd   = $fopen("tb/decode_stim.txt", "r");
        done = 1'b0;
        if (fd == 0) begin
            $display("Error: cannot open the stimulus file tb/decode_stim.txt");
            other_errors++;
            done = 1'b1;
        end
        while (!done && line_no < MAX_LINES) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                line_no++;
                if (kind == "#") begin
                    code = $fgets(skipped, fd);
                end else if (kind == "W") begin
                    code = $fscanf(fd, "%h %h", w_addr, w_data);
                    if (code != 2) begin
                        $display("Error: unreadable write line %0d", line_no);
                        other_errors++;
                    end else begin
                        apply_write(w_addr[4:0], w_data);
                    end
                end else if (kind == "D") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   pc_v, instr_v, rs_sel_v, rt_sel_v, exp_alu, exp_src_a,
                                   exp_src_b, exp_ls, exp_wena, exp_dst, exp_imme, exp_ri,
                                   exp_take, exp_target);
                    if (code != 14) begin
                        $display("Error: unreadable decode line %0d", line_no);
                        other_errors++;
                    end else begin
                        check_decode();
                    end
                end else begin
                    $display("Error: unknown record kind on line %0d", line_no);
                    other_errors++;
                end
            end
        end
        if (!done) begin
            $display("Error: stimulus file did not end within %0d lines", MAX_LINES);
            other_errors++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    initial begin : main_flow
        int cycles;
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_in     = '0;
        fwd_rs_sel   = FWD_REG;
        fwd_rt_sel   = FWD_REG;
        fwd          = '0;
        wb           = '0;
        rand_state   = 32'hc311_0bf0;
        mismatches   = 0;
        other_errors = 0;
        line_no      = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end

        cycles = 0;
        while (rst === 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            #3;
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("Error: reset was never released");
            other_errors++;
        end else begin
            // output register still holds its reset contents here
            if (out.valid !== 1'b0) report_mismatch("valid", out.valid, 32'd0);
            if (out.take_jmp !== 1'b0) report_mismatch("take_jmp", out.take_jmp, 32'd0);
            if (out.ctrl.w_reg_ena !== 1'b0) begin
                report_mismatch("w_reg_ena", out.ctrl.w_reg_ena, 32'd0);
            end
            if (out.ctrl.ls_op !== LS_NOP) report_mismatch("ls_op", out.ctrl.ls_op, LS_NOP);
            if (out.ctrl.alu_op !== ALU_NOP) report_mismatch("alu_op", out.ctrl.alu_op, ALU_NOP);
            run_stimulus();
        end

        $display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/decode_stim.txt
# W reg_addr data
# D pc instr rs_sel rt_sel alu_op src_a src_b ls_op w_reg_ena w_reg_dst ext_imme is_ri
#   take_jmp jmp_target (ffffffff means the rs operand, 0 when not taken)
W 01 00000005
W 02 00000005
W 03 fffffff0
W 04 00001000
D 00400000 00222820 0 0 1 0 1 0 1 05 00002820 0 0 00000000
D 00400004 00033100 1 2 9 1 4 0 1 06 00003100 0 0 00000000
D 00400008 00233807 3 0 b 1 3 0 1 07 00003807 0 0 00000000
D 0040000c 00230022 0 3 2 0 1 0 0 00 00000022 0 0 00000000
D 00400010 2008fffc 0 0 1 0 2 0 1 08 fffffffc 0 0 00000000
D 00400014 34298001 2 1 6 0 2 0 1 09 00008001 0 0 00000000
D 00400018 8c8bfff8 0 0 1 0 2 5 1 0b fffffff8 0 0 00000000
D 0040001c 908c0010 0 0 1 0 2 2 1 0c 00000010 0 0 00000000
D 00400020 ac828004 0 0 1 0 2 8 0 02 ffff8004 0 0 00000000
D 00400100 10220010 0 0 0 0 0 0 0 00 00000010 0 1 00400144
D 00400100 10230010 0 0 0 0 0 0 0 00 00000010 0 0 00000000
D 00400100 1423fffc 0 0 0 0 0 0 0 00 0000fffc 0 1 004000f4
D 00400100 1422fffc 0 0 0 0 0 0 0 00 0000fffc 0 0 00000000
D 00400100 18600010 0 0 0 0 0 0 0 00 00000010 0 1 00400144
D 00400100 18200010 0 0 0 0 0 0 0 00 00000010 0 0 00000000
D 00400100 1c200010 0 0 0 0 0 0 0 00 00000010 0 1 00400144
D 00400100 04600010 0 0 0 0 0 0 0 00 00000010 0 1 00400144
D 00400100 04200010 0 0 0 0 0 0 0 00 00000010 0 0 00000000
D 00400100 04210010 0 0 0 0 0 0 0 00 00000010 0 1 00400144
D 00400100 04610010 0 0 0 0 0 0 0 00 00000010 0 0 00000000
D 50000100 08100040 0 0 0 0 0 0 0 00 00000040 0 1 50400100
D 50000104 0c100040 0 0 0 0 0 0 1 1f 00000040 0 1 50400100
W 00 deadbeef
D 00400100 1c000010 0 0 0 0 0 0 0 00 00000010 0 0 00000000
D 00400200 00800008 0 0 0 0 0 0 0 00 00000008 0 1 ffffffff
D 00400204 0080f809 1 0 0 0 0 0 1 1f 0000f809 0 1 ffffffff
D 00400208 fc000000 0 0 0 0 0 0 0 00 00000000 1 0 00000000
D 0040020c 0022283f 0 0 0 0 0 0 0 00 0000283f 1 0 00000000

//--- sources.f
design/isa_pkg.sv
design/ctrl_pkg.sv
design/operand_fetch.sv
design/ctrl_decode.sv
design/branch_issue.sv
design/decode_stage.sv
tb/tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - design/isa_pkg.sv
  - design/ctrl_pkg.sv
  - design/operand_fetch.sv
  - design/ctrl_decode.sv
  - design/branch_issue.sv
  - design/decode_stage.sv
  - target: simulation
    files:
      - tb/tb_decode_stage.sv
